//--- barrel_core.f
barrel_pkg.sv
core_if.sv
thread_ctl.sv
regfile.sv
issue_stage.sv
exec_unit.sv
barrel_core.sv
barrel_core_tb.sv

//--- barrel_core.sv
`timescale 1ns/1ps

module barrel_core #(
  parameter int NUM_THREADS = 4,
  parameter int IADDR_W     = 10
) (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          start,
  output logic                          ics,
  output logic [IADDR_W-1:0]            iaddr,
  input  logic [barrel_pkg::DATA_W-1:0] idata,
  output logic                          dcs,
  output logic                          dwr,
  output logic [barrel_pkg::DATA_W-1:0] daddr,
  output logic [barrel_pkg::DATA_W-1:0] dout,
  input  logic [barrel_pkg::DATA_W-1:0] din,
  output logic [NUM_THREADS-1:0]        halted
);

  localparam int SLICE_W = $clog2(NUM_THREADS);

  logic [SLICE_W-1:0]               slice;
  logic                             redirect;
  logic [SLICE_W-1:0]               redirect_slice;
  logic [IADDR_W-1:0]               redirect_pc;
  logic                             halt_req;
  logic [barrel_pkg::REG_SEL_W-1:0] ra_sel;
  logic [barrel_pkg::REG_SEL_W-1:0] rb_sel;
  logic [barrel_pkg::DATA_W-1:0]    ra_val;
  logic [barrel_pkg::DATA_W-1:0]    rb_val;

  issue_if #(.NUM_THREADS(NUM_THREADS)) issue_bus ();
  wb_if    #(.NUM_THREADS(NUM_THREADS)) wb_bus ();

  thread_ctl #(
    .NUM_THREADS (NUM_THREADS),
    .IADDR_W     (IADDR_W)
  ) thread_ctl_i (
    .CLK            (CLK),
    .rst            (rst),
    .start          (start),
    .redirect       (redirect),
    .redirect_slice (redirect_slice),
    .redirect_pc    (redirect_pc),
    .halt_req       (halt_req),
    .ics            (ics),
    .iaddr          (iaddr),
    .slice          (slice),
    .halted         (halted)
  );

  issue_stage #(.NUM_THREADS(NUM_THREADS)) issue_stage_i (
    .CLK    (CLK),
    .rst    (rst),
    .ics    (ics),
    .slice  (slice),
    .idata  (idata),
    .ra_val (ra_val),
    .rb_val (rb_val),
    .ra_sel (ra_sel),
    .rb_sel (rb_sel),
    .issue  (issue_bus.source)
  );

  // The register file follows the fetch slice and lines it up with the returning word
  regfile #(.NUM_THREADS(NUM_THREADS)) regfile_i (
    .CLK      (CLK),
    .rst      (rst),
    .slice_rd (slice),
    .ra_sel   (ra_sel),
    .rb_sel   (rb_sel),
    .wb       (wb_bus.sink),
    .ra_val   (ra_val),
    .rb_val   (rb_val)
  );

  exec_unit #(
    .NUM_THREADS (NUM_THREADS),
    .IADDR_W     (IADDR_W)
  ) exec_unit_i (
    .CLK            (CLK),
    .rst            (rst),
    .issue          (issue_bus.sink),
    .din            (din),
    .dcs            (dcs),
    .dwr            (dwr),
    .daddr          (daddr),
    .dout           (dout),
    .redirect       (redirect),
    .redirect_slice (redirect_slice),
    .redirect_pc    (redirect_pc),
    .halt_req       (halt_req),
    .wb             (wb_bus.source)
  );

endmodule

//--- barrel_core_tb.sv
`timescale 1ns/1ps

module barrel_core_tb;

  localparam int NUM_THREADS = 4;
  localparam int IADDR_W     = 10;
  localparam int NUM_GROUPS  = 3;
  localparam int DATA_BASE   = 512;
  localparam int AREA_WORDS  = 16;
  localparam int MAX_STORES  = 16;
  localparam logic [15:0] LOOP_MARK = 16'h7e57;

  typedef struct packed {
    barrel_pkg::opcode_e op;
    logic [15:0]         imm;
  } row_t;

  // Four consecutive rows make one group, row t of a group runs on thread t
  // For bz rows the immediate is the loop count, for ld rows the word offset
  localparam row_t STIM_TABLE [NUM_GROUPS*NUM_THREADS] = '{
    '{barrel_pkg::op_add,  16'h0000},
    '{barrel_pkg::op_sub,  16'h0000},
    '{barrel_pkg::op_and,  16'h0000},
    '{barrel_pkg::op_or,   16'h0000},
    '{barrel_pkg::op_xor,  16'h0000},
    '{barrel_pkg::op_addi, 16'h0123},
    '{barrel_pkg::op_addi, 16'hfff0},
    '{barrel_pkg::op_ld,   16'h0005},
    '{barrel_pkg::op_bz,   16'h0003},
    '{barrel_pkg::op_bz,   16'h0001},
    '{barrel_pkg::op_ld,   16'h0009},
    '{barrel_pkg::op_bz,   16'h0004}
  };

  logic                   clk;
  logic                   rst;
  logic                   start;
  logic                   ics;
  logic [IADDR_W-1:0]     iaddr;
  logic [31:0]            idata = '0;
  logic                   dcs;
  logic                   dwr;
  logic [31:0]            daddr;
  logic [31:0]            dout;
  logic [31:0]            din = '0;
  logic [NUM_THREADS-1:0] halted;

  logic [31:0] rom [1 << IADDR_W];
  logic [31:0] ram [1024];
  logic [15:0] lfsr_state;
  int          errors;
  logic [31:0] exp_addr [NUM_THREADS][MAX_STORES];
  logic [31:0] exp_data [NUM_THREADS][MAX_STORES];
  int          exp_n    [NUM_THREADS];
  logic [31:0] obs_addr [NUM_THREADS][MAX_STORES];
  logic [31:0] obs_data [NUM_THREADS][MAX_STORES];
  int          obs_n    [NUM_THREADS];

  barrel_core #(
    .NUM_THREADS (NUM_THREADS),
    .IADDR_W     (IADDR_W)
  ) barrel_core_i (
    .CLK    (clk),
    .rst    (rst),
    .start  (start),
    .ics    (ics),
    .iaddr  (iaddr),
    .idata  (idata),
    .dcs    (dcs),
    .dwr    (dwr),
    .daddr  (daddr),
    .dout   (dout),
    .din    (din),
    .halted (halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Instruction ROM and data RAM, both answer one cycle after the request
  always @(posedge clk) begin
    if (ics) begin
      idata <= rom[iaddr];
    end
    if (dcs && dwr) begin
      ram[daddr[9:0]] = dout;
    end else if (dcs) begin
      din <= ram[daddr[9:0]];
    end
  end

  always @(posedge clk) begin : bus_monitor
    int slot;
    if (rst) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        obs_n[t] = 0;
      end
    end else begin
      if (dcs && dwr) begin
        slot = (int'(daddr) - DATA_BASE) / AREA_WORDS;
        assert (int'(daddr) >= DATA_BASE && slot < NUM_THREADS) else begin
          errors++;
          $display("[FAIL] %0t: store to 0x%0h outside the thread data areas", $time, daddr);
        end
        if (int'(daddr) >= DATA_BASE && slot < NUM_THREADS) begin
          if (obs_n[slot] < MAX_STORES) begin
            obs_addr[slot][obs_n[slot]] = daddr;
            obs_data[slot][obs_n[slot]] = dout;
          end
          obs_n[slot]++;
        end
      end
      assert (!(ics && halted[iaddr[7:6]])) else begin
        errors++;
        $display("[FAIL] %0t: fetch at 0x%0h from halted thread %0d", $time, iaddr, iaddr[7:6]);
      end
      assert (!(dcs && (&halted))) else begin
        errors++;
        $display("[FAIL] %0t: data access after all threads halted", $time);
      end
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hb400;
    end
    return n;
  endfunction

  task automatic draw_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [31:0] encode_instr(barrel_pkg::opcode_e op, int rd, int ra,
                                               int rb, logic [15:0] imm);
    logic [31:0] w;
    w = '0;
    w[barrel_pkg::OPC_MSB:barrel_pkg::OPC_LSB] = op;
    w[barrel_pkg::RD_MSB:barrel_pkg::RD_LSB]   = rd[2:0];
    w[barrel_pkg::RA_MSB:barrel_pkg::RA_LSB]   = ra[2:0];
    w[barrel_pkg::RB_MSB:barrel_pkg::RB_LSB]   = rb[2:0];
    w[barrel_pkg::IMM_MSB:barrel_pkg::IMM_LSB] = imm;
    return w;
  endfunction

  function automatic logic [31:0] expected_value(barrel_pkg::opcode_e op, logic [31:0] a,
                                                 logic [31:0] b, logic [15:0] imm);
    case (op)
      barrel_pkg::op_add:  return a + b;
      barrel_pkg::op_sub:  return a - b;
      barrel_pkg::op_and:  return a & b;
      barrel_pkg::op_or:   return a | b;
      barrel_pkg::op_xor:  return a ^ b;
      barrel_pkg::op_addi: return a + {{16{imm[15]}}, imm};
      // A load returns the word placed at the offset
      default:             return b;
    endcase
  endfunction

  task automatic record_expect(int t, int addr, logic [31:0] data);
    exp_addr[t][exp_n[t]] = 32'(addr);
    exp_data[t][exp_n[t]] = data;
    exp_n[t]++;
  endtask

  task automatic fill_memories();
    for (int i = 0; i < 1024; i++) begin
      rom[i] = encode_instr(barrel_pkg::op_halt, 0, 0, 0, 16'(i));
      ram[i] = 32'(i) * 32'h9e3779b1;
    end
    for (int t = 0; t < NUM_THREADS; t++) begin
      exp_n[t] = 0;
    end
  endtask

  // Register r0 is never written, so it reads as zero in every program
  task automatic load_program(int t, row_t row);
    int          base;
    int          area;
    logic [31:0] a;
    logic [31:0] b;
    base = t * barrel_pkg::THREAD_PC_STRIDE;
    area = DATA_BASE + t * AREA_WORDS;
    draw_word(a);
    draw_word(b);
    ram[area]     = a;
    ram[area + 1] = b;
    case (row.op)
      barrel_pkg::op_bz: begin
        rom[base]     = encode_instr(barrel_pkg::op_addi, 1, 0, 0, row.imm);
        rom[base + 1] = encode_instr(barrel_pkg::op_st, 0, 0, 1, 16'(area));
        rom[base + 2] = encode_instr(barrel_pkg::op_addi, 1, 1, 0, 16'hffff);
        rom[base + 3] = encode_instr(barrel_pkg::op_bz, 0, 1, 0, 16'(base + 5));
        rom[base + 4] = encode_instr(barrel_pkg::op_bz, 0, 0, 0, 16'(base + 1));
        rom[base + 5] = encode_instr(barrel_pkg::op_addi, 2, 0, 0, LOOP_MARK);
        rom[base + 6] = encode_instr(barrel_pkg::op_st, 0, 0, 2, 16'(area));
        rom[base + 7] = encode_instr(barrel_pkg::op_halt, 0, 0, 0, 16'h0);
        for (int n = int'(row.imm); n > 0; n--) begin
          record_expect(t, area, 32'(n));
        end
        record_expect(t, area, 32'(LOOP_MARK));
      end
      barrel_pkg::op_addi: begin
        rom[base]     = encode_instr(barrel_pkg::op_ld, 1, 0, 0, 16'(area));
        rom[base + 1] = encode_instr(barrel_pkg::op_addi, 3, 1, 0, row.imm);
        rom[base + 2] = encode_instr(barrel_pkg::op_st, 0, 0, 3, 16'(area + 2));
        rom[base + 3] = encode_instr(barrel_pkg::op_halt, 0, 0, 0, 16'h0);
        record_expect(t, area + 2, expected_value(row.op, a, b, row.imm));
      end
      barrel_pkg::op_ld: begin
        ram[area + int'(row.imm)] = b;
        rom[base]     = encode_instr(barrel_pkg::op_addi, 4, 0, 0, 16'(area));
        rom[base + 1] = encode_instr(barrel_pkg::op_ld, 3, 4, 0, row.imm);
        rom[base + 2] = encode_instr(barrel_pkg::op_st, 0, 4, 3, 16'd2);
        rom[base + 3] = encode_instr(barrel_pkg::op_halt, 0, 0, 0, 16'h0);
        record_expect(t, area + 2, expected_value(row.op, a, b, row.imm));
      end
      default: begin
        rom[base]     = encode_instr(barrel_pkg::op_ld, 1, 0, 0, 16'(area));
        rom[base + 1] = encode_instr(barrel_pkg::op_ld, 2, 0, 0, 16'(area + 1));
        rom[base + 2] = encode_instr(row.op, 3, 1, 2, 16'h0);
        rom[base + 3] = encode_instr(barrel_pkg::op_st, 0, 0, 3, 16'(area + 2));
        rom[base + 4] = encode_instr(barrel_pkg::op_halt, 0, 0, 0, 16'h0);
        record_expect(t, area + 2, expected_value(row.op, a, b, row.imm));
      end
    endcase
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  // Nothing may move on either port while the threads wait for start
  task automatic check_idle();
    repeat (4) begin
      @(posedge clk);
      assert (!ics && !dcs && !dwr && halted == '0) else begin
        errors++;
        $display("[FAIL] %0t: activity before start, ics=%b dcs=%b dwr=%b halted=%b",
                 $time, ics, dcs, dwr, halted);
      end
    end
  endtask

  task automatic check_stores(int g);
    for (int t = 0; t < NUM_THREADS; t++) begin
      assert (obs_n[t] == exp_n[t]) else begin
        errors++;
        $display("[FAIL] %0t: group %0d thread %0d made %0d stores, expected %0d",
                 $time, g, t, obs_n[t], exp_n[t]);
      end
      for (int i = 0; i < exp_n[t] && i < obs_n[t] && i < MAX_STORES; i++) begin
        assert (obs_addr[t][i] == exp_addr[t][i] && obs_data[t][i] == exp_data[t][i])
        else begin
          errors++;
          $display("[FAIL] %0t: group %0d thread %0d store %0d got 0x%0h@0x%0h, expected 0x%0h@0x%0h",
                   $time, g, t, i, obs_data[t][i], obs_addr[t][i],
                   exp_data[t][i], exp_addr[t][i]);
        end
      end
    end
  endtask

  initial begin
    errors     = 0;
    lfsr_state = 16'd23097;
    rst        = 1'b1;
    start      = 1'b0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      fill_memories();
      for (int t = 0; t < NUM_THREADS; t++) begin
        load_program(t, STIM_TABLE[g * NUM_THREADS + t]);
      end
      reset_dut();
      check_idle();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      while (halted != '1) begin
        @(posedge clk);
      end
      // A few more cycles so the monitor can catch stray fetches or accesses
      repeat (8) @(posedge clk);
      check_stores(g);
    end
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (NUM_GROUPS * 200) @(posedge clk);
    $display("Timeout: threads did not all halt in %0d cycles, %0d errors so far",
             NUM_GROUPS * 200, errors);
    $display("Errors found");
    $finish;
  end

endmodule

//--- barrel_pkg.sv
package barrel_pkg;

  localparam int DATA_W    = 32;
  localparam int REG_SEL_W = 3;
  localparam int NUM_REGS  = 8;
  localparam int IMM_W     = 16;

  // Instruction word layout, also used by the program assembler in the testbench
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  localparam int RD_MSB  = 26;
  localparam int RD_LSB  = 24;
  localparam int RA_MSB  = 22;
  localparam int RA_LSB  = 20;
  localparam int RB_MSB  = 18;
  localparam int RB_LSB  = 16;
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 0;

  // Thread t starts executing at word address t * THREAD_PC_STRIDE
  localparam int THREAD_PC_STRIDE = 64;

  // Codes above op_halt are treated as no-ops by the issue stage
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_addi = 4'd5,
    op_ld   = 4'd6,
    op_st   = 4'd7,
    op_bz   = 4'd8,
    op_halt = 4'd9
  } opcode_e;

  typedef enum logic [1:0] {
    ts_idle,
    ts_run,
    ts_halt
  } thread_state_e;

endpackage

//--- core_if.sv
`timescale 1ns/1ps

// Decoded instruction bundle handed from the issue stage to the execute unit
interface issue_if #(
  parameter int NUM_THREADS = 4
);
  localparam int SLICE_W = $clog2(NUM_THREADS);

  logic                               vld;
  logic [SLICE_W-1:0]                 slice;
  barrel_pkg::opcode_e                opcode;
  logic [barrel_pkg::REG_SEL_W-1:0]   rd;
  logic [barrel_pkg::DATA_W-1:0]      ra_val;
  logic [barrel_pkg::DATA_W-1:0]      rb_val;
  // Already sign-extended to the full data width
  logic [barrel_pkg::DATA_W-1:0]      imm;

  modport source (output vld, slice, opcode, rd, ra_val, rb_val, imm);
  modport sink   (input  vld, slice, opcode, rd, ra_val, rb_val, imm);

endinterface

// Register writeback from the execute unit into one bank of the register file
interface wb_if #(
  parameter int NUM_THREADS = 4
);
  localparam int SLICE_W = $clog2(NUM_THREADS);

  logic                               vld;
  logic [SLICE_W-1:0]                 slice;
  logic [barrel_pkg::REG_SEL_W-1:0]   sel;
  logic [barrel_pkg::DATA_W-1:0]      data;

  modport source (output vld, slice, sel, data);
  modport sink   (input  vld, slice, sel, data);

endinterface

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
  parameter int NUM_THREADS = 4,
  parameter int IADDR_W     = 10,
  localparam int SLICE_W    = $clog2(NUM_THREADS)
) (
  input  logic                          CLK,
  input  logic                          rst,
  issue_if.sink                         issue,
  input  logic [barrel_pkg::DATA_W-1:0] din,
  output logic                          dcs,
  output logic                          dwr,
  output logic [barrel_pkg::DATA_W-1:0] daddr,
  output logic [barrel_pkg::DATA_W-1:0] dout,
  output logic                          redirect,
  output logic [SLICE_W-1:0]            redirect_slice,
  output logic [IADDR_W-1:0]            redirect_pc,
  output logic                          halt_req,
  wb_if.source                          wb
);

  logic [barrel_pkg::DATA_W-1:0] sum;
  logic [barrel_pkg::DATA_W-1:0] result;
  logic                          writes_rd;
  logic                          is_ld;
  logic                          is_st;
  logic [barrel_pkg::DATA_W-1:0] res_q;
  logic                          ld_q;

  // Shared adder for addi and for load/store addresses
  assign sum   = issue.ra_val + issue.imm;
  assign is_ld = (issue.opcode == barrel_pkg::op_ld);
  assign is_st = (issue.opcode == barrel_pkg::op_st);

  always_comb begin
    writes_rd = 1'b1;
    case (issue.opcode)
      barrel_pkg::op_add:  result = issue.ra_val + issue.rb_val;
      barrel_pkg::op_sub:  result = issue.ra_val - issue.rb_val;
      barrel_pkg::op_and:  result = issue.ra_val & issue.rb_val;
      barrel_pkg::op_or:   result = issue.ra_val | issue.rb_val;
      barrel_pkg::op_xor:  result = issue.ra_val ^ issue.rb_val;
      barrel_pkg::op_addi: result = sum;
      barrel_pkg::op_ld:   result = sum;
      default: begin
        result    = sum;
        writes_rd = 1'b0;
      end
    endcase
  end

  assign dcs   = issue.vld && (is_ld || is_st);
  assign dwr   = issue.vld && is_st;
  assign daddr = sum;
  assign dout  = issue.rb_val;

  // Branch target is an absolute word address held in the immediate
  assign redirect       = issue.vld && issue.opcode == barrel_pkg::op_bz && issue.ra_val == '0;
  assign redirect_slice = issue.slice;
  assign redirect_pc    = issue.imm[IADDR_W-1:0];
  assign halt_req       = issue.vld && issue.opcode == barrel_pkg::op_halt;

  always_ff @(posedge CLK) begin
    if (rst) begin
      wb.vld <= 1'b0;
    end else begin
      wb.vld <= issue.vld && writes_rd;
    end
  end

  always_ff @(posedge CLK) begin
    wb.slice <= issue.slice;
    wb.sel   <= issue.rd;
    res_q    <= result;
    ld_q     <= is_ld;
  end

  // Load data arrives from the synchronous RAM one cycle after the request
  assign wb.data = ld_q ? din : res_q;

  a_store_no_wb : assert property (@(posedge CLK) disable iff (rst)
    dwr |-> dcs ##1 !wb.vld);

endmodule

//--- issue_stage.sv
`timescale 1ns/1ps

module issue_stage #(
  parameter int NUM_THREADS = 4,
  localparam int SLICE_W    = $clog2(NUM_THREADS)
) (
  input  logic                               CLK,
  input  logic                               rst,
  input  logic                               ics,
  input  logic [SLICE_W-1:0]                 slice,
  input  logic [barrel_pkg::DATA_W-1:0]      idata,
  input  logic [barrel_pkg::DATA_W-1:0]      ra_val,
  input  logic [barrel_pkg::DATA_W-1:0]      rb_val,
  output logic [barrel_pkg::REG_SEL_W-1:0]   ra_sel,
  output logic [barrel_pkg::REG_SEL_W-1:0]   rb_sel,
  issue_if.source                            issue
);

  logic                             ics_d;
  logic [SLICE_W-1:0]               slice_d;
  barrel_pkg::opcode_e              opcode;
  logic [barrel_pkg::IMM_W-1:0]     imm_raw;
  logic                             known_op;

  // Tag the instruction word that comes back one cycle after the fetch
  always_ff @(posedge CLK) begin
    if (rst) begin
      ics_d   <= 1'b0;
      slice_d <= '0;
    end else begin
      ics_d   <= ics;
      slice_d <= slice;
    end
  end

  assign opcode  = barrel_pkg::opcode_e'(idata[barrel_pkg::OPC_MSB:barrel_pkg::OPC_LSB]);
  assign imm_raw = idata[barrel_pkg::IMM_MSB:barrel_pkg::IMM_LSB];
  assign ra_sel  = idata[barrel_pkg::RA_MSB:barrel_pkg::RA_LSB];
  assign rb_sel  = idata[barrel_pkg::RB_MSB:barrel_pkg::RB_LSB];

  always_comb begin
    case (opcode)
      barrel_pkg::op_add, barrel_pkg::op_sub, barrel_pkg::op_and,
      barrel_pkg::op_or, barrel_pkg::op_xor, barrel_pkg::op_addi,
      barrel_pkg::op_ld, barrel_pkg::op_st, barrel_pkg::op_bz,
      barrel_pkg::op_halt: known_op = 1'b1;
      default:             known_op = 1'b0;
    endcase
  end

  // Unknown codes simply drop out here and never reach execute
  always_ff @(posedge CLK) begin
    if (rst) begin
      issue.vld <= 1'b0;
    end else begin
      issue.vld <= ics_d && known_op;
    end
  end

  always_ff @(posedge CLK) begin
    issue.slice  <= slice_d;
    issue.opcode <= opcode;
    issue.rd     <= idata[barrel_pkg::RD_MSB:barrel_pkg::RD_LSB];
    issue.ra_val <= ra_val;
    issue.rb_val <= rb_val;
    issue.imm    <= barrel_pkg::DATA_W'(signed'(imm_raw));
  end

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile #(
  parameter int NUM_THREADS = 4,
  localparam int SLICE_W    = $clog2(NUM_THREADS)
) (
  input  logic                               CLK,
  input  logic                               rst,
  input  logic [SLICE_W-1:0]                 slice_rd,
  input  logic [barrel_pkg::REG_SEL_W-1:0]   ra_sel,
  input  logic [barrel_pkg::REG_SEL_W-1:0]   rb_sel,
  wb_if.sink                                 wb,
  output logic [barrel_pkg::DATA_W-1:0]      ra_val,
  output logic [barrel_pkg::DATA_W-1:0]      rb_val
);

  logic [barrel_pkg::DATA_W-1:0] regs [NUM_THREADS][barrel_pkg::NUM_REGS];
  logic [SLICE_W-1:0]            rd_bank;

  // Operands are read the cycle after the fetch, when the instruction word returns
  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_bank <= '0;
    end else begin
      rd_bank <= slice_rd;
    end
  end

  always_comb begin
    ra_val = regs[rd_bank][ra_sel];
    rb_val = regs[rd_bank][rb_sel];
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int b = 0; b < NUM_THREADS; b++) begin
        for (int r = 0; r < barrel_pkg::NUM_REGS; r++) begin
          regs[b][r] <= '0;
        end
      end
    end else if (wb.vld) begin
      regs[wb.slice][wb.sel] <= wb.data;
    end
  end

  // The slice rotation keeps the writing thread two turns away from the
  // reading one, so no bypass path is needed
  a_no_bank_conflict : assert property (@(posedge CLK) disable iff (rst)
    wb.vld |-> wb.slice != rd_bank);

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module barrel_core_tb -f barrel_core.f -o barrel_sim

./obj_dir/barrel_sim > sim.log
cat sim.log

if grep -qx "No errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- thread_ctl.sv
`timescale 1ns/1ps

module thread_ctl #(
  parameter int NUM_THREADS = 4,
  parameter int IADDR_W     = 10,
  localparam int SLICE_W    = $clog2(NUM_THREADS)
) (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   redirect,
  input  logic [SLICE_W-1:0]     redirect_slice,
  input  logic [IADDR_W-1:0]     redirect_pc,
  input  logic                   halt_req,
  output logic                   ics,
  output logic [IADDR_W-1:0]     iaddr,
  output logic [SLICE_W-1:0]     slice,
  output logic [NUM_THREADS-1:0] halted
);

  barrel_pkg::thread_state_e state [NUM_THREADS];
  logic [IADDR_W-1:0]        pc    [NUM_THREADS];
  logic [SLICE_W-1:0]        slice_nxt;

  assign slice_nxt = slice + SLICE_W'(1);

  // The fetch port is registered, so the decision for the next slice is made
  // one cycle ahead from that thread's state and program counter
  always_ff @(posedge CLK) begin
    if (rst) begin
      slice <= '0;
      ics   <= 1'b0;
    end else begin
      slice <= slice_nxt;
      ics   <= (state[slice_nxt] == barrel_pkg::ts_run);
    end
  end

  always_ff @(posedge CLK) begin
    iaddr <= pc[slice_nxt];
  end

  // Per-thread run state
  // A halt from the execute unit wins over everything, a halted thread waits for reset
  always_ff @(posedge CLK) begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      if (rst) begin
        state[t] <= barrel_pkg::ts_idle;
      end else begin
        case (state[t])
          barrel_pkg::ts_idle: begin
            if (start) begin
              state[t] <= barrel_pkg::ts_run;
            end
          end
          barrel_pkg::ts_run: begin
            if (halt_req && redirect_slice == SLICE_W'(t)) begin
              state[t] <= barrel_pkg::ts_halt;
            end
          end
          default: state[t] <= barrel_pkg::ts_halt;
        endcase
      end
    end
  end

  // Program counters
  // A taken branch lands two cycles after the fetch, well before the next turn
  always_ff @(posedge CLK) begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      if (rst) begin
        pc[t] <= IADDR_W'(t * barrel_pkg::THREAD_PC_STRIDE);
      end else if (redirect && redirect_slice == SLICE_W'(t)) begin
        pc[t] <= redirect_pc;
      end else if (ics && slice == SLICE_W'(t)) begin
        pc[t] <= pc[t] + IADDR_W'(1);
      end
    end
  end

  always_comb begin
    for (int t = 0; t < NUM_THREADS; t++) begin
      halted[t] = (state[t] == barrel_pkg::ts_halt);
    end
  end

  // The fetch decision is taken a cycle early, so a halt arriving from the execute
  // unit must never leave a stale fetch behind for the stopped thread
  a_fetch_only_running : assert property (@(posedge CLK) disable iff (rst)
    ics |-> state[slice] == barrel_pkg::ts_run);

endmodule
